// File: verilog/iso14443a_pkg.sv
`default_nettype none

package iso14443a_pkg;

    // modified miller sequences as seen over one bit period
    typedef enum logic [1:0] {
        seq_x,
        seq_y,
        seq_z,
        seq_error
    } pcd_bit_sequence;

    // clk cycles per bit period (fc/128)
    localparam int BIT_CYCLES = 128;
    // nominal position of the pause in an X period
    localparam int HALF_BIT = 64;
    // allowed distance of a pause from its nominal position
    localparam int EDGE_TOL = 8;

    // shortest low run taken as a real pause
    localparam int PAUSE_MIN_CYCLES = 6;
    // high run needed before another pause can fire
    localparam int PAUSE_REARM_CYCLES = 4;

    // this many Y periods in a row and the bit timer stops
    localparam int IDLE_Y_LIMIT = 3;

    // crc_a preset and reflected polynomial (x^16 + x^12 + x^5 + 1)
    localparam logic [15:0] CRC_A_INIT = 16'h6363;
    localparam logic [15:0] CRC_A_POLY = 16'h8408;

    // counter widths derived from the timing above
    localparam int BIT_CNT_W = $clog2(BIT_CYCLES);
    localparam int PAUSE_CNT_W = $clog2(PAUSE_MIN_CYCLES + 1);
    localparam int REARM_CNT_W = $clog2(PAUSE_REARM_CYCLES + 1);
    localparam int Y_RUN_W = $clog2(IDLE_Y_LIMIT);

endpackage

`default_nettype wire

// File: verilog/pause_filter.sv
`timescale 1ns/1ps
`default_nettype none

module pause_filter (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic carrier,
    output logic      pause_start
);

    import iso14443a_pkg::*;

    // two stage synchroniser, carrier idles high
    logic [1:0]             sync;
    // consecutive low cycles seen after the synchroniser
    logic [PAUSE_CNT_W-1:0] low_cnt;
    // consecutive high cycles, used to re-arm
    logic [REARM_CNT_W-1:0] high_cnt;
    // set when the next long low run may fire a pulse
    logic                   armed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync        <= 2'b11;
            low_cnt     <= '0;
            high_cnt    <= '0;
            armed       <= 1'b1;
            pause_start <= 1'b0;
        end else begin
            sync        <= {sync[0], carrier};
            pause_start <= 1'b0;

            if (!sync[1]) begin
                // inside a pause, count up and saturate
                high_cnt <= '0;
                if (low_cnt != PAUSE_CNT_W'(PAUSE_MIN_CYCLES)) begin
                    low_cnt <= low_cnt + 1'b1;
                end
                // fires on the cycle the run reaches the minimum
                if (armed && low_cnt == PAUSE_CNT_W'(PAUSE_MIN_CYCLES - 1)) begin
                    pause_start <= 1'b1;
                    armed       <= 1'b0;
                end
            end else begin
                low_cnt <= '0;
                if (high_cnt != REARM_CNT_W'(PAUSE_REARM_CYCLES)) begin
                    high_cnt <= high_cnt + 1'b1;
                end
                // short high blips (ringing) don't get here
                if (high_cnt == REARM_CNT_W'(PAUSE_REARM_CYCLES - 1)) begin
                    armed <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/sequence_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sequence_decode (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       pause_start,
    output iso14443a_pkg::pcd_bit_sequence  sd_seq,
    output logic                            sd_seq_valid
);

    import iso14443a_pkg::*;

    // bit timer running
    logic                 active;
    // position inside the current bit period
    logic [BIT_CNT_W-1:0] bit_cnt;
    // pauses seen this period, saturates at 2
    logic [1:0]           pause_cnt;
    // the first pause landed in the Z or X window
    logic                 z_hit;
    logic                 x_hit;
    // consecutive Y periods
    logic [Y_RUN_W-1:0]   y_run;

    // view of the period including this cycle's pause
    logic                 in_z_win;
    logic                 in_x_win;
    logic                 accept;
    logic                 z_now;
    logic                 x_now;
    logic [1:0]           cnt_now;
    logic                 period_end;

    always_comb begin
        // while idle bit_cnt sits at 0 so the first pause is a Z
        in_z_win = (bit_cnt <= BIT_CNT_W'(EDGE_TOL));
        in_x_win = (bit_cnt >= BIT_CNT_W'(HALF_BIT - EDGE_TOL)) &&
                   (bit_cnt <= BIT_CNT_W'(HALF_BIT + EDGE_TOL));
        // only the first pause of a period can be accepted
        accept = pause_start && (pause_cnt == 2'd0) && (in_z_win || in_x_win);
        z_now = z_hit || (accept && in_z_win);
        x_now = x_hit || (accept && in_x_win);

        if (pause_start && pause_cnt != 2'd2) begin
            cnt_now = pause_cnt + 2'd1;
        end else begin
            cnt_now = pause_cnt;
        end

        // classify the period
        if (cnt_now == 2'd0) begin
            sd_seq = seq_y;
        end else if (cnt_now == 2'd1 && z_now) begin
            sd_seq = seq_z;
        end else if (cnt_now == 2'd1 && x_now) begin
            sd_seq = seq_x;
        end else begin
            // two pauses or one outside both windows
            sd_seq = seq_error;
        end

        period_end = active && (bit_cnt == BIT_CNT_W'(BIT_CYCLES - 1));
    end

    assign sd_seq_valid = period_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            bit_cnt   <= '0;
            pause_cnt <= 2'd0;
            z_hit     <= 1'b0;
            x_hit     <= 1'b0;
            y_run     <= '0;
        end else if (period_end) begin
            // start a fresh period
            bit_cnt   <= '0;
            pause_cnt <= 2'd0;
            z_hit     <= 1'b0;
            x_hit     <= 1'b0;
            if (sd_seq == seq_y) begin
                if (y_run == Y_RUN_W'(IDLE_Y_LIMIT - 1)) begin
                    // frame is over, wait for the next SOC pause
                    active <= 1'b0;
                    y_run  <= '0;
                end else begin
                    y_run <= y_run + 1'b1;
                end
            end else begin
                y_run <= '0;
            end
        end else if (active || pause_start) begin
            active    <= 1'b1;
            pause_cnt <= cnt_now;
            z_hit     <= z_now;
            x_hit     <= x_now;
            if (accept) begin
                // pull the timer onto the pause, this cycle is the nominal slot
                bit_cnt <= in_z_win ? BIT_CNT_W'(1) : BIT_CNT_W'(HALF_BIT + 1);
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/frame_decode.sv
`timescale 1ns/1ps
`default_nettype none

module frame_decode (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire iso14443a_pkg::pcd_bit_sequence sd_seq,
    input  wire logic                           sd_seq_valid,
    output logic                                soc,
    output logic                                eoc,
    output logic [7:0]                          data,
    // 0 means all eight bits are valid
    output logic [2:0]                          data_bits,
    output logic                                data_valid,
    output logic                                sequence_error,
    output logic                                parity_error
);

    import iso14443a_pkg::*;

    // between soc and eoc
    logic            in_frame;
    // decisions are made on the previous sequence so the
    // logic 0 in front of the closing Y is never taken as data
    pcd_bit_sequence last_seq;
    logic            bit_val;
    // at least one bit (or error) after soc
    logic            got_data;
    // eight data bits in, parity bit is next
    logic            want_parity;
    // running odd parity of the current byte
    logic            parity_exp;
    // hold off data until eoc
    logic            err_seen;
    logic            is_eoc;
    logic            take_bit;

    // X carries a 1, Y and Z carry a 0
    assign bit_val = (last_seq == seq_x);

    // Y after Y or Z ends the frame
    assign is_eoc = (sd_seq == seq_y) && (last_seq == seq_y || last_seq == seq_z);

    // strobe on which last_seq is stored as a data bit
    assign take_bit = sd_seq_valid && in_frame && !is_eoc && !err_seen &&
                      (last_seq != seq_error) && !want_parity;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            soc            <= 1'b0;
            eoc            <= 1'b0;
            data_valid     <= 1'b0;
            sequence_error <= 1'b0;
            parity_error   <= 1'b0;
            data_bits      <= 3'd0;
            in_frame       <= 1'b0;
            last_seq       <= seq_y;
            got_data       <= 1'b0;
            want_parity    <= 1'b0;
            parity_exp     <= 1'b1;
            err_seen       <= 1'b0;
        end else begin
            // all outputs are single cycle pulses
            soc            <= 1'b0;
            eoc            <= 1'b0;
            data_valid     <= 1'b0;
            sequence_error <= 1'b0;
            parity_error   <= 1'b0;

            if (sd_seq_valid) begin
                last_seq <= sd_seq;

                if (!in_frame) begin
                    // Ys here are just the idle tail of the last frame
                    if (last_seq == seq_z) begin
                        soc         <= 1'b1;
                        in_frame    <= 1'b1;
                        data_bits   <= 3'd0;
                        got_data    <= 1'b0;
                        want_parity <= 1'b0;
                        parity_exp  <= 1'b1;
                        err_seen    <= 1'b0;
                    end
                end else if (is_eoc) begin
                    eoc      <= 1'b1;
                    in_frame <= 1'b0;
                    // a full byte must be followed by its parity bit
                    if (want_parity) begin
                        parity_error <= 1'b1;
                    end
                    // ZY with nothing between
                    if (!got_data) begin
                        sequence_error <= 1'b1;
                    end
                    // release a trailing partial byte
                    if (!want_parity && got_data && !err_seen && data_bits != 3'd0) begin
                        data_valid <= 1'b1;
                    end
                end else if (!err_seen) begin
                    got_data <= 1'b1;
                    if (last_seq == seq_error) begin
                        sequence_error <= 1'b1;
                        err_seen       <= 1'b1;
                        // keeps eoc from adding a parity error
                        want_parity    <= 1'b0;
                    end else if (want_parity) begin
                        want_parity <= 1'b0;
                        if (bit_val == parity_exp) begin
                            data_valid <= 1'b1;
                            parity_exp <= 1'b1;
                        end else begin
                            parity_error <= 1'b1;
                            err_seen     <= 1'b1;
                        end
                    end else begin
                        parity_exp  <= parity_exp ^ bit_val;
                        want_parity <= (data_bits == 3'd7);
                        // wraps to 0 after bit 7, ready for the next byte
                        data_bits   <= data_bits + 3'd1;
                    end
                end
            end
        end
    end

    // byte shift register, LSB first
    always_ff @(posedge clk) begin
        if (take_bit) begin
            if (data_bits == 3'd0) begin
                // first bit of a byte clears the stale upper bits
                data <= {7'd0, bit_val};
            end else begin
                data[data_bits] <= bit_val;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/crc_a_check.sv
`timescale 1ns/1ps
`default_nettype none

module crc_a_check (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       soc,
    input  wire logic       eoc,
    input  wire logic [7:0] data,
    input  wire logic [2:0] data_bits,
    input  wire logic       data_valid,
    output logic            crc_ok
);

    import iso14443a_pkg::*;

    // running crc over the full bytes of the frame
    logic [15:0] crc;

    // fold one byte in, LSB first, reflected form
    function automatic logic [15:0] crc_a_byte(input logic [15:0] crc_in,
                                               input logic [7:0] byte_in);
        logic [15:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ byte_in[i]) begin
                c = (c >> 1) ^ CRC_A_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= CRC_A_INIT;
        end else if (soc) begin
            crc <= CRC_A_INIT;
        end else if (data_valid && data_bits == 3'd0) begin
            // partial bytes never reach the crc
            crc <= crc_a_byte(crc, data);
        end
    end

    // appended crc bytes leave a zero residue
    // only meaningful while eoc is high
    assign crc_ok = eoc && (crc == 16'h0000);

endmodule

`default_nettype wire

// File: verilog/iso14443a_rx.sv
`timescale 1ns/1ps
`default_nettype none

module iso14443a_rx (
    input  wire logic       clk,
    input  wire logic       rst_n,
    // low while the reader pauses the carrier
    input  wire logic       carrier,
    output logic            soc,
    output logic            eoc,
    output logic [7:0]      data,
    output logic [2:0]      data_bits,
    output logic            data_valid,
    output logic            sequence_error,
    output logic            parity_error,
    output logic            crc_ok
);

    import iso14443a_pkg::*;

    // one pulse per accepted pause
    logic            pause_start;
    // one sequence per bit period
    pcd_bit_sequence sd_seq;
    logic            sd_seq_valid;

    pause_filter u_pause_filter (
        .clk         (clk),
        .rst_n       (rst_n),
        .carrier     (carrier),
        .pause_start (pause_start)
    );

    sequence_decode u_sequence_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .pause_start  (pause_start),
        .sd_seq       (sd_seq),
        .sd_seq_valid (sd_seq_valid)
    );

    frame_decode u_frame_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .sd_seq         (sd_seq),
        .sd_seq_valid   (sd_seq_valid),
        .soc            (soc),
        .eoc            (eoc),
        .data           (data),
        .data_bits      (data_bits),
        .data_valid     (data_valid),
        .sequence_error (sequence_error),
        .parity_error   (parity_error)
    );

    // taps the frame_decode outputs alongside the outside world
    crc_a_check u_crc_a_check (
        .clk        (clk),
        .rst_n      (rst_n),
        .soc        (soc),
        .eoc        (eoc),
        .data       (data),
        .data_bits  (data_bits),
        .data_valid (data_valid),
        .crc_ok     (crc_ok)
    );

endmodule

`default_nettype wire

// File: include/pcd_stim.svh
`ifndef PCD_STIM_SVH
`define PCD_STIM_SVH

// reader side stimulus included inside the testbench module
// uses clk, carrier and PAUSE_LEN of the including module

// xorshift32 step for random payload
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// drive one bit period where seq_error gives pauses at both slots
task automatic drive_period(input iso14443a_pkg::pcd_bit_sequence s);
    logic at_start;
    logic at_half;
    at_start = (s == iso14443a_pkg::seq_z) || (s == iso14443a_pkg::seq_error);
    at_half = (s == iso14443a_pkg::seq_x) || (s == iso14443a_pkg::seq_error);
    for (int i = 0; i < iso14443a_pkg::BIT_CYCLES; i++) begin
        @(posedge clk);
        carrier <= !((at_start && i < PAUSE_LEN) ||
                     (at_half && i >= iso14443a_pkg::HALF_BIT &&
                      i < iso14443a_pkg::HALF_BIT + PAUSE_LEN));
    end
endtask

// logic 1 is X and logic 0 is Y after a 1 or Z otherwise
task automatic miller_bit(input logic b, inout logic last_one);
    if (b) begin
        drive_period(iso14443a_pkg::seq_x);
    end else if (last_one) begin
        drive_period(iso14443a_pkg::seq_y);
    end else begin
        drive_period(iso14443a_pkg::seq_z);
    end
    last_one = b;
endtask

// SOC is a Z and counts as a logic 0 for the next bit
task automatic open_frame(output logic last_one);
    drive_period(iso14443a_pkg::seq_z);
    last_one = 1'b0;
endtask

// eight bits LSB first and then odd parity that bad_parity inverts
task automatic byte_with_parity(input logic [7:0] b, input logic bad_parity,
                                inout logic last_one);
    for (int i = 0; i < 8; i++) begin
        miller_bit(b[i], last_one);
    end
    miller_bit((~^b) ^ bad_parity, last_one);
endtask

// short frame of n bits with no parity
task automatic short_bits(input logic [7:0] b, input int n, inout logic last_one);
    for (int i = 0; i < n; i++) begin
        miller_bit(b[i], last_one);
    end
endtask

// end of frame is a logic 0 followed by Y
task automatic close_frame(inout logic last_one);
    miller_bit(1'b0, last_one);
    drive_period(iso14443a_pkg::seq_y);
endtask

// quiet bit periods between frames
task automatic idle_gap(input int n);
    for (int i = 0; i < n; i++) begin
        drive_period(iso14443a_pkg::seq_y);
    end
endtask

// carrier dip of len cycles and then the rest of one bit period high
task automatic carrier_dip(input int len);
    for (int i = 0; i < iso14443a_pkg::BIT_CYCLES; i++) begin
        @(posedge clk);
        carrier <= !(i < len);
    end
endtask

`endif

// File: bench/tb_iso14443a_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_iso14443a_rx;

    import iso14443a_pkg::*;

    // reader pause width in clk cycles
    localparam int PAUSE_LEN = 28;
    // idle bit periods after every frame
    localparam int FRAME_GAP = 4;
    localparam int RESET_CYCLES = 4;
    // bit periods sent over the whole run
    // each frame costs its SOC, its bits, two EOF periods and the gap
    localparam int TOTAL_PERIODS = 2 + (3 + 6 * 9 + FRAME_GAP) + (3 + 7 + FRAME_GAP) +
        (3 + 3 * 9 + FRAME_GAP) + (4 + 2 * 9 + FRAME_GAP) + (3 + 4 * 9 + FRAME_GAP) +
        (3 + FRAME_GAP) + 2 * (3 + 3 * 9 + FRAME_GAP) + 2 + FRAME_GAP;
    // 20 percent margin on top of the stimulus length
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_PERIODS * BIT_CYCLES * 6 / 5;

    // one expected output cycle of the DUT
    typedef struct packed {
        logic       soc;
        logic       eoc;
        logic       dv;
        logic [7:0] data;
        logic [2:0] bits;
        logic       seq_err;
        logic       par_err;
        logic       crc_ok;
    } rx_event_t;

    logic       clk;
    logic       rst_n;
    logic       carrier;
    logic       soc;
    logic       eoc;
    logic [7:0] data;
    logic [2:0] data_bits;
    logic       data_valid;
    logic       sequence_error;
    logic       parity_error;
    logic       crc_ok;

    rx_event_t   exp_q[$];
    rx_event_t   exp_ev;
    logic [7:0]  payload[$];
    // crc model over the bytes expected in the current frame
    logic [15:0] model_crc;
    logic [31:0] rng_state = 32'h85af_90b3;
    int          cycle_cnt = 0;

    iso14443a_rx u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .carrier        (carrier),
        .soc            (soc),
        .eoc            (eoc),
        .data           (data),
        .data_bits      (data_bits),
        .data_valid     (data_valid),
        .sequence_error (sequence_error),
        .parity_error   (parity_error),
        .crc_ok         (crc_ok)
    );

    `include "pcd_stim.svh"

    always #2 clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input int got, input int want);
        assert (got == want) else begin
            fail_now($sformatf("Error at %0t: %s = 0x%0h, expected 0x%0h",
                               $time, name, got, want));
        end
    endtask

    // reflected crc_a taken one data bit at a time from the LSB
    function automatic logic [15:0] fold_crc(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] r;
        logic        fb;
        r = crc;
        for (int k = 0; k < 8; k++) begin
            fb = r[0] ^ b[k];
            r = {1'b0, r[15:1]} ^ ({16{fb}} & CRC_A_POLY);
        end
        return r;
    endfunction

    task automatic load_random(input int n);
        payload.delete();
        for (int i = 0; i < n; i++) begin
            rng_state = xorshift32(rng_state);
            payload.push_back(rng_state[7:0]);
        end
    endtask

    // low byte of the check value goes out first
    task automatic append_crc(input logic flip);
        logic [15:0] c;
        c = CRC_A_INIT;
        foreach (payload[i]) begin
            c = fold_crc(c, payload[i]);
        end
        payload.push_back(c[7:0]);
        payload.push_back(flip ? ~c[15:8] : c[15:8]);
    endtask

    task automatic push_event(input logic s, input logic e, input logic dv,
                              input logic [7:0] d, input logic [2:0] n,
                              input logic serr, input logic perr);
        rx_event_t ev;
        ev.soc = s;
        ev.eoc = e;
        ev.dv = dv;
        ev.data = d;
        ev.bits = n;
        ev.seq_err = serr;
        ev.par_err = perr;
        // zero residue means the appended check value was right
        ev.crc_ok = (model_crc == 16'h0000);
        exp_q.push_back(ev);
    endtask

    task automatic expect_soc();
        model_crc = CRC_A_INIT;
        push_event(1'b1, 1'b0, 1'b0, 8'h00, 3'd0, 1'b0, 1'b0);
    endtask

    task automatic expect_byte(input logic [7:0] b);
        push_event(1'b0, 1'b0, 1'b1, b, 3'd0, 1'b0, 1'b0);
        model_crc = fold_crc(model_crc, b);
    endtask

    // eoc may share its cycle with a partial byte or a sequence error
    task automatic expect_eoc(input logic serr, input logic dv, input logic [7:0] d,
                              input logic [2:0] n);
        push_event(1'b0, 1'b1, dv, d, n, serr, 1'b0);
    endtask

    task automatic expect_clean_frame();
        expect_soc();
        foreach (payload[i]) begin
            expect_byte(payload[i]);
        end
        expect_eoc(1'b0, 1'b0, 8'h00, 3'd0);
    endtask

    // bad_idx picks the byte whose parity is inverted and -1 picks none
    task automatic send_frame(input int bad_idx);
        logic last_one;
        open_frame(last_one);
        foreach (payload[i]) begin
            byte_with_parity(payload[i], i == bad_idx, last_one);
        end
        close_frame(last_one);
        idle_gap(FRAME_GAP);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_now($sformatf("timeout after %0d cycles, the run did not finish", cycle_cnt));
        end
    end

    // outputs move on the rising edge so compare on the falling one
    always @(negedge clk) begin
        if (rst_n && (soc || eoc || data_valid || sequence_error || parity_error)) begin
            if (exp_q.size() == 0) begin
                fail_now($sformatf("output pulse at %0t with no event left to match", $time));
            end else begin
                exp_ev = exp_q.pop_front();
                check_value("soc", int'(soc), int'(exp_ev.soc));
                check_value("eoc", int'(eoc), int'(exp_ev.eoc));
                check_value("data_valid", int'(data_valid), int'(exp_ev.dv));
                check_value("sequence_error", int'(sequence_error), int'(exp_ev.seq_err));
                check_value("parity_error", int'(parity_error), int'(exp_ev.par_err));
                if (exp_ev.dv) begin
                    check_value("data", int'(data), int'(exp_ev.data));
                    check_value("data_bits", int'(data_bits), int'(exp_ev.bits));
                end
                // crc_ok only carries meaning in the eoc cycle
                if (exp_ev.eoc) begin
                    check_value("crc_ok", int'(crc_ok), int'(exp_ev.crc_ok));
                end
            end
        end
    end

    initial begin : stimulus
        logic last_one;
        clk = 1'b0;
        rst_n = 1'b0;
        carrier = 1'b1;
        model_crc = CRC_A_INIT;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        idle_gap(2);

        // four random bytes with a correct crc_a
        load_random(4);
        append_crc(1'b0);
        expect_clean_frame();
        send_frame(-1);

        // 7 bit short frame without parity
        expect_soc();
        expect_eoc(1'b0, 1'b1, 8'h26, 3'd7);
        open_frame(last_one);
        short_bits(8'h26, 7, last_one);
        close_frame(last_one);
        idle_gap(FRAME_GAP);

        // second byte with bad parity and the rest dropped
        load_random(3);
        expect_soc();
        expect_byte(payload[0]);
        push_event(1'b0, 1'b0, 1'b0, 8'h00, 3'd0, 1'b0, 1'b1);
        expect_eoc(1'b0, 1'b0, 8'h00, 3'd0);
        send_frame(1);

        // two pauses in one bit period after the first byte
        load_random(2);
        expect_soc();
        expect_byte(payload[0]);
        push_event(1'b0, 1'b0, 1'b0, 8'h00, 3'd0, 1'b1, 1'b0);
        expect_eoc(1'b0, 1'b0, 8'h00, 3'd0);
        open_frame(last_one);
        byte_with_parity(payload[0], 1'b0, last_one);
        drive_period(seq_error);
        // the mid-period pause leaves the line as after an X
        last_one = 1'b1;
        byte_with_parity(payload[1], 1'b0, last_one);
        close_frame(last_one);
        idle_gap(FRAME_GAP);

        // corrupted crc byte but all bytes still delivered
        load_random(2);
        append_crc(1'b1);
        expect_clean_frame();
        send_frame(-1);

        // SOC straight into EOC
        expect_soc();
        expect_eoc(1'b1, 1'b0, 8'h00, 3'd0);
        open_frame(last_one);
        close_frame(last_one);
        idle_gap(FRAME_GAP);

        // short dips between two frames must not start a frame
        load_random(3);
        expect_clean_frame();
        send_frame(-1);
        carrier_dip(3);
        carrier_dip(PAUSE_MIN_CYCLES - 1);
        idle_gap(FRAME_GAP);
        load_random(3);
        expect_clean_frame();
        send_frame(-1);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
verilog/iso14443a_pkg.sv
verilog/pause_filter.sv
verilog/sequence_decode.sv
verilog/frame_decode.sv
verilog/crc_a_check.sv
verilog/iso14443a_rx.sv
bench/tb_iso14443a_rx.sv

// File: run.sh
#!/usr/bin/env bash
# build the iso14443a receiver testbench with Verilator and run it
# the verdict comes from the simulation log

cd "$(dirname "$0")" || exit 1

log=sim.log
top=tb_iso14443a_rx

rm -rf obj_dir "$log"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$top" -f filelist.f \
    && { ./obj_dir/V"$top" > "$log" 2>&1 || true; } \
    || { echo "verilator build failed"; exit 1; }

cat "$log"
grep -q "=== FAIL ===" "$log" && { echo "simulation reported a failure"; exit 1; }
grep -q "=== PASS ===" "$log" || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
